// ==== Bender.yml ====
package:
  name: boot_fetch

sources:
  - boot_fetch_pkg.sv
  - bootrom.sv
  - fetch_unit.sv
  - line_queue.sv
  - insn_decoder.sv
  - boot_fetch_top.sv
  - target: test
    files:
      - boot_fetch_assertions.sv
      - boot_fetch_tb.sv

// ==== boot_fetch.f ====
boot_fetch_pkg.sv
bootrom.sv
fetch_unit.sv
line_queue.sv
insn_decoder.sv
boot_fetch_top.sv
boot_fetch_assertions.sv
boot_fetch_tb.sv

// ==== boot_fetch_assertions.sv ====
`timescale 1ns/1ps

module boot_fetch_assertions (
    input logic                              clk_i,
    input logic                              rst_i,
    input logic                              bus_cyc_i,
    input logic                              bus_stb_i,
    input logic                              bus_cs_i,
    input logic [boot_fetch_pkg::ADDR_W-1:0] bus_adr_i,
    input logic                              bus_ack_i,
    input logic                              q_push_i,
    input logic                              q_full_i,
    input logic                              flush_i,
    input logic                              insn_valid_i,
    input logic                              halted_i
);

    int assert_errors = 0;

    // the ROM may only acknowledge inside a live cycle
    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_ack_i |-> (bus_cyc_i && bus_stb_i && bus_cs_i))
    else begin
        $error("bus acknowledge seen outside a live bus cycle");
        assert_errors++;
    end

    // an open cycle keeps its address until the acknowledge
    a_adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (bus_cyc_i && !bus_ack_i) |=> $stable(bus_adr_i))
    else begin
        $error("bus address changed during an open cycle");
        assert_errors++;
    end

    // a push into a full queue is only harmless when the flush eats it
    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
        (q_push_i && q_full_i) |-> flush_i)
    else begin
        $error("line pushed into a full queue without a flush");
        assert_errors++;
    end

    // once halted the decoder stays quiet
    a_quiet_halted: assert property (@(posedge clk_i) disable iff (rst_i)
        halted_i |-> !insn_valid_i)
    else begin
        $error("instruction valid while halted");
        assert_errors++;
    end

endmodule

bind boot_fetch_top boot_fetch_assertions u_assert (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .bus_cyc_i    (bus_cyc),
    .bus_stb_i    (bus_stb),
    .bus_cs_i     (bus_cs),
    .bus_adr_i    (bus_adr),
    .bus_ack_i    (bus_ack),
    .q_push_i     (q_push),
    .q_full_i     (q_full),
    .flush_i      (redirect),
    .insn_valid_i (insn_valid_o),
    .halted_i     (halted_o)
);

// ==== boot_fetch_pkg.sv ====
package boot_fetch_pkg;

    // ========================================
    // sizes of the fetch path
    // ========================================

    // byte address width covers 32 lines of 16 bytes
    localparam int ADDR_W      = 9;
    localparam int LINE_W      = 128;
    localparam int INSN_W      = 32;
    localparam int ROM_LINES   = 32;
    // line index is address bits 8 down to 4
    localparam int LINE_IDX_W  = 5;
    localparam int QUEUE_DEPTH = 4;

    // first byte address fetched after reset
    localparam logic [ADDR_W-1:0] RESET_PC = '0;

    // ========================================
    // encodings
    // ========================================

    // F_DROP waits out a bus cycle whose line is thrown away after a redirect
    typedef enum logic [1:0] {
        F_IDLE = 2'd0,
        F_BUS  = 2'd1,
        F_DROP = 2'd2,
        F_PUSH = 2'd3
    } fetch_state_e;

    // opcode lives in instruction bits 31 to 29
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_ALU   = 3'd1,
        OP_LOAD  = 3'd2,
        OP_STORE = 3'd3,
        OP_JMP   = 3'd4,
        OP_HALT  = 3'd5
    } insn_op_e;

    // the two spare codes decode as a no-op
    function automatic insn_op_e decode_op(input logic [2:0] code);
        if (code > 3'd5) begin
            return OP_NOP;
        end
        return insn_op_e'(code);
    endfunction

endpackage

// ==== boot_fetch_tb.sv ====
`timescale 1ns/1ps

module boot_fetch_tb;

    localparam int CLK_PERIOD = 20;

    logic                              clk;
    logic                              rst;
    logic                              stall;
    logic                              insn_valid;
    logic [boot_fetch_pkg::INSN_W-1:0] insn;
    logic [boot_fetch_pkg::ADDR_W-1:0] insn_pc;
    boot_fetch_pkg::insn_op_e          insn_op;
    logic                              halted;

    // reference stream walked from the same ROM image
    logic [boot_fetch_pkg::LINE_W-1:0] rom_image [boot_fetch_pkg::ROM_LINES];
    logic [boot_fetch_pkg::INSN_W-1:0] exp_insn [$];
    logic [boot_fetch_pkg::ADDR_W-1:0] exp_pc [$];
    boot_fetch_pkg::insn_op_e          exp_op [$];
    int                                first_jump;
    int                                stream_idx;
    int                                errors;
    int                                checks;
    bit                                model_ready = 1'b0;
    logic [31:0]                       rng_state;

    boot_fetch_top dut0 (
        .clk_i        (clk),
        .rst_i        (rst),
        .stall_i      (stall),
        .insn_valid_o (insn_valid),
        .insn_o       (insn),
        .insn_pc_o    (insn_pc),
        .insn_op_o    (insn_op),
        .halted_o     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================
    // reference model and helpers
    // ========================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // opcode field is bits 31 to 29 and the spare codes read as no-op
    function automatic boot_fetch_pkg::insn_op_e op_of(input logic [31:0] w);
        case (w[31:29])
            3'd1:    return boot_fetch_pkg::OP_ALU;
            3'd2:    return boot_fetch_pkg::OP_LOAD;
            3'd3:    return boot_fetch_pkg::OP_STORE;
            3'd4:    return boot_fetch_pkg::OP_JMP;
            3'd5:    return boot_fetch_pkg::OP_HALT;
            default: return boot_fetch_pkg::OP_NOP;
        endcase
    endfunction

    task automatic build_model();
        logic [boot_fetch_pkg::ADDR_W-1:0] pc;
        logic [boot_fetch_pkg::INSN_W-1:0] w;
        boot_fetch_pkg::insn_op_e          op;
        int                                steps;
        $readmemh("boot_rom.mem", rom_image);
        pc = boot_fetch_pkg::RESET_PC;
        op = boot_fetch_pkg::OP_NOP;
        first_jump = -1;
        steps = 0;
        // the walk is capped in case the image never reaches a halt
        while (op != boot_fetch_pkg::OP_HALT && steps < 1024) begin
            w  = rom_image[pc[8:4]][pc[3:2]*32 +: 32];
            op = op_of(w);
            exp_insn.push_back(w);
            exp_pc.push_back(pc);
            exp_op.push_back(op);
            if (op == boot_fetch_pkg::OP_JMP && first_jump < 0) begin
                first_jump = exp_op.size() - 1;
            end
            pc = (op == boot_fetch_pkg::OP_JMP) ? w[8:0] : pc + 9'd4;
            steps++;
        end
        if (op != boot_fetch_pkg::OP_HALT) begin
            $display("model error: the ROM image never reaches a halt");
            errors++;
        end
    endtask

    task automatic check_insn(
        input logic [boot_fetch_pkg::INSN_W-1:0] got_insn,
        input logic [boot_fetch_pkg::ADDR_W-1:0] got_pc,
        input boot_fetch_pkg::insn_op_e          got_op,
        input logic [boot_fetch_pkg::INSN_W-1:0] want_insn,
        input logic [boot_fetch_pkg::ADDR_W-1:0] want_pc,
        input boot_fetch_pkg::insn_op_e          want_op,
        input string                             what
    );
        checks++;
        if (got_insn !== want_insn || got_pc !== want_pc || got_op !== want_op) begin
            errors++;
            $display("[FAIL] %0t: %s: got %h at pc %h (%s), expected %h at pc %h (%s)",
                     $time, what, got_insn, got_pc, got_op.name(),
                     want_insn, want_pc, want_op.name());
        end
    endtask

    task automatic check_pc(input logic [boot_fetch_pkg::ADDR_W-1:0] got,
                            input logic [boot_fetch_pkg::ADDR_W-1:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s: pc %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_valid(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s: insn_valid %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_halted(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s: halted %b, expected %b", $time, what, got, want);
        end
    endtask

    // reset is held for four rising edges while the outputs are watched
    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_valid(insn_valid, 1'b0, "valid during reset");
            check_halted(halted, 1'b0, "halted during reset");
        end
        rst = 1'b0;
        stream_idx = 0;
    endtask

    // consumes the stream up to stop_at and takes an instruction at the
    // rising edge that sees valid high and stall low
    task automatic run_stream(input bit random_stall, input int stop_at);
        bit                                held;
        bit                                after_jump;
        logic [boot_fetch_pkg::INSN_W-1:0] held_insn;
        logic [boot_fetch_pkg::ADDR_W-1:0] held_pc;
        boot_fetch_pkg::insn_op_e          held_op;
        logic [boot_fetch_pkg::ADDR_W-1:0] jump_target;
        held = 1'b0;
        after_jump = 1'b0;
        jump_target = '0;
        while (stream_idx < stop_at) begin
            @(negedge clk);
            if (held) begin
                check_valid(insn_valid, 1'b1, "valid under stall");
                check_insn(insn, insn_pc, insn_op, held_insn, held_pc, held_op, "held output");
            end
            check_halted(halted, 1'b0, "halted before the halt was taken");
            if (random_stall) begin
                rng_state = xorshift(rng_state);
                stall = (rng_state[2:0] < 3'd3);
            end else begin
                stall = 1'b0;
            end
            held = insn_valid && stall;
            held_insn = insn;
            held_pc = insn_pc;
            held_op = insn_op;
            if (insn_valid && !stall) begin
                check_insn(insn, insn_pc, insn_op, exp_insn[stream_idx], exp_pc[stream_idx],
                           exp_op[stream_idx], "stream");
                // the word after a jump sits at the target field of the model's jump
                if (after_jump) begin
                    check_pc(insn_pc, jump_target, "jump target");
                end
                after_jump = (exp_op[stream_idx] == boot_fetch_pkg::OP_JMP);
                jump_target = exp_insn[stream_idx][8:0];
                stream_idx++;
            end
        end
        stall = 1'b0;
    endtask

    // ========================================
    // directed tests
    // ========================================

    task automatic reset_and_park();
        // a stall on the way out of reset parks the first instruction
        stall = 1'b1;
        apply_reset();
        while (!insn_valid) begin
            @(negedge clk);
        end
        check_pc(insn_pc, boot_fetch_pkg::RESET_PC, "first pc after reset");
        repeat (3) begin
            @(negedge clk);
            check_insn(insn, insn_pc, insn_op, exp_insn[0], exp_pc[0], exp_op[0],
                       "first instruction under stall");
        end
    endtask

    task automatic sequential_stream();
        run_stream(1'b0, first_jump);
    endtask

    task automatic follow_jumps();
        run_stream(1'b0, exp_insn.size());
    endtask

    task automatic hold_after_halt();
        @(negedge clk);
        check_halted(halted, 1'b1, "halted after the halt");
        repeat (50) begin
            @(negedge clk);
            check_valid(insn_valid, 1'b0, "valid after halt");
            check_halted(halted, 1'b1, "halted held");
        end
    endtask

    task automatic stalled_stream();
        apply_reset();
        run_stream(1'b1, exp_insn.size());
        hold_after_halt();
    endtask

    // reset lands right after the first jump, while its redirect is still live
    task automatic restart_mid_stream();
        apply_reset();
        run_stream(1'b0, first_jump + 1);
        apply_reset();
        run_stream(1'b0, exp_insn.size());
        hold_after_halt();
    endtask

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        errors = 0;
        checks = 0;
        stream_idx = 0;
        rng_state = 32'h8e9b_c9ae;
        build_model();
        model_ready = 1'b1;
        reset_and_park();
        sequential_stream();
        follow_jumps();
        hold_after_halt();
        stalled_stream();
        restart_mid_stream();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_assert.assert_errors);
        if (errors == 0 && dut0.u_assert.assert_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog sized from three full passes plus the partial one
    initial begin
        int limit;
        wait (model_ready);
        limit = (3 * exp_insn.size() + first_jump + 1) * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== boot_fetch_top.sv ====
`timescale 1ns/1ps

module boot_fetch_top (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              stall_i,
    output logic                              insn_valid_o,
    output logic [boot_fetch_pkg::INSN_W-1:0] insn_o,
    output logic [boot_fetch_pkg::ADDR_W-1:0] insn_pc_o,
    output boot_fetch_pkg::insn_op_e          insn_op_o,
    output logic                              halted_o
);

    // bus between the fetch unit and the ROM
    logic                              bus_cyc;
    logic                              bus_stb;
    logic                              bus_cs;
    logic [boot_fetch_pkg::ADDR_W-1:0] bus_adr;
    logic                              bus_ack;
    logic [boot_fetch_pkg::LINE_W-1:0] bus_dat;

    // queue push and pop sides
    logic                              q_full;
    logic                              q_push;
    logic [boot_fetch_pkg::LINE_W-1:0] q_line;
    logic [boot_fetch_pkg::ADDR_W-1:0] q_line_addr;
    logic                              q_empty;
    logic [boot_fetch_pkg::LINE_W-1:0] q_head_line;
    logic [boot_fetch_pkg::ADDR_W-1:0] q_head_addr;
    logic                              q_pop;

    // redirect doubles as the queue flush
    logic                              redirect;
    logic [boot_fetch_pkg::ADDR_W-1:0] redirect_pc;

    fetch_unit u_fetch (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .bus_cyc_o     (bus_cyc),
        .bus_stb_o     (bus_stb),
        .bus_cs_o      (bus_cs),
        .bus_adr_o     (bus_adr),
        .bus_ack_i     (bus_ack),
        .bus_dat_i     (bus_dat),
        .q_full_i      (q_full),
        .q_push_o      (q_push),
        .q_line_o      (q_line),
        .q_line_addr_o (q_line_addr),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc)
    );

    bootrom u_rom (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cs_i  (bus_cs),
        .cyc_i (bus_cyc),
        .stb_i (bus_stb),
        .adr_i (bus_adr),
        .ack_o (bus_ack),
        .dat_o (bus_dat)
    );

    line_queue u_queue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (redirect),
        .push_i      (q_push),
        .line_i      (q_line),
        .line_addr_i (q_line_addr),
        .pop_i       (q_pop),
        .full_o      (q_full),
        .empty_o     (q_empty),
        .head_line_o (q_head_line),
        .head_addr_o (q_head_addr)
    );

    insn_decoder u_decoder (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .q_empty_i     (q_empty),
        .q_head_line_i (q_head_line),
        .q_head_addr_i (q_head_addr),
        .q_pop_o       (q_pop),
        .stall_i       (stall_i),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .insn_valid_o  (insn_valid_o),
        .insn_o        (insn_o),
        .insn_pc_o     (insn_pc_o),
        .insn_op_o     (insn_op_o),
        .halted_o      (halted_o)
    );

endmodule

// ==== boot_rom.mem ====
// one 128-bit line per row, 32 hex digits, word slot 3 on the left and slot 0 on the right
0000100C600010084000100420001000
2000101C40001018C000101420001010
2000102C400010282000102460001020
2000103C000010388000005820001030
2000104C200010482000104420001040
4000105C200010584000105420001050
2000106C20001068800000A460001060
2000107C200010782000107420001070
2000108C200010882000108420001080
2000109C200010982000109420001090
200010AC800000C0200010A4200010A0
200010BC200010B8200010B4200010B0
200010CC600010C8400010C4200010C0
200010DC800000EC200010D4E00010D0
200010EC200010E8200010E4200010E0
200010FCA0000000600010F4400010F0
2000110C200011082000110420001100
2000111C200011182000111420001110
2000112C200011282000112420001120
2000113C200011382000113420001130
2000114C200011482000114420001140
2000115C200011582000115420001150
2000116C200011682000116420001160
2000117C200011782000117420001170
2000118C200011882000118420001180
2000119C200011982000119420001190
200011AC200011A8200011A4200011A0
200011BC200011B8200011B4200011B0
200011CC200011C8200011C4200011C0
200011DC200011D8200011D4200011D0
200011EC200011E8200011E4200011E0
200011FC200011F8200011F4200011F0

// ==== bootrom.sv ====
`timescale 1ns/1ps

module bootrom (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              cs_i,
    input  logic                              cyc_i,
    input  logic                              stb_i,
    input  logic [boot_fetch_pkg::ADDR_W-1:0] adr_i,
    output logic                              ack_o,
    output logic [boot_fetch_pkg::LINE_W-1:0] dat_o
);

    logic [boot_fetch_pkg::LINE_W-1:0]     rom_mem [boot_fetch_pkg::ROM_LINES];
    logic [boot_fetch_pkg::LINE_IDX_W-1:0] radr;
    logic                                  sel;
    logic                                  ack1;
    logic                                  ack2;

    // the image is loaded once at start of simulation or from the bitstream
    initial begin
        $readmemh("boot_rom.mem", rom_mem);
    end

    // the cycle is only live when all three levels are up
    assign sel = cs_i && cyc_i && stb_i;

    // acknowledge never shows outside a live cycle
    assign ack_o = sel && ack2;

    // each acknowledge stage falls as soon as the select drops
    // so a back to back cycle again waits two edges
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack1 <= 1'b0;
            ack2 <= 1'b0;
        end else begin
            ack1 <= sel;
            ack2 <= ack1 && sel;
        end
    end

    // first stage latches the line index out of the byte address
    always_ff @(posedge clk_i) begin
        radr <= adr_i[boot_fetch_pkg::ADDR_W-1 -: boot_fetch_pkg::LINE_IDX_W];
    end

    // second stage reads the line in step with ack2
    always_ff @(posedge clk_i) begin
        dat_o <= rom_mem[radr];
    end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                              clk_i,
    input  logic                              rst_i,
    output logic                              bus_cyc_o,
    output logic                              bus_stb_o,
    output logic                              bus_cs_o,
    output logic [boot_fetch_pkg::ADDR_W-1:0] bus_adr_o,
    input  logic                              bus_ack_i,
    input  logic [boot_fetch_pkg::LINE_W-1:0] bus_dat_i,
    input  logic                              q_full_i,
    output logic                              q_push_o,
    output logic [boot_fetch_pkg::LINE_W-1:0] q_line_o,
    output logic [boot_fetch_pkg::ADDR_W-1:0] q_line_addr_o,
    input  logic                              redirect_i,
    input  logic [boot_fetch_pkg::ADDR_W-1:0] redirect_pc_i
);

    boot_fetch_pkg::fetch_state_e          state;
    // next line to fetch and the line of the cycle now on the bus
    logic [boot_fetch_pkg::LINE_IDX_W-1:0] next_idx;
    logic [boot_fetch_pkg::LINE_IDX_W-1:0] cur_idx;
    logic [boot_fetch_pkg::LINE_IDX_W-1:0] inc_idx;
    logic                                  in_flight;

    // a cycle is on the bus in F_BUS and in F_DROP alike
    assign in_flight = (state == boot_fetch_pkg::F_BUS) || (state == boot_fetch_pkg::F_DROP);

    assign bus_cyc_o = in_flight;
    assign bus_stb_o = in_flight;
    assign bus_cs_o  = in_flight;

    // the address comes from cur_idx, which only changes in F_IDLE
    // so it stays put for the whole cycle even if a redirect arrives
    assign bus_adr_o     = {cur_idx, 4'b0000};
    assign q_line_addr_o = {cur_idx, 4'b0000};

    // the captured line goes out once the queue has room
    assign q_push_o = (state == boot_fetch_pkg::F_PUSH) && !q_full_i;

    // line counter wraps at the end of the ROM
    assign inc_idx = (next_idx == boot_fetch_pkg::LINE_IDX_W'(boot_fetch_pkg::ROM_LINES - 1)) ?
                     '0 : next_idx + 1'b1;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= boot_fetch_pkg::F_IDLE;
            next_idx <= boot_fetch_pkg::RESET_PC[boot_fetch_pkg::ADDR_W-1 -: boot_fetch_pkg::LINE_IDX_W];
            cur_idx  <= boot_fetch_pkg::RESET_PC[boot_fetch_pkg::ADDR_W-1 -: boot_fetch_pkg::LINE_IDX_W];
        end else begin
            case (state)
                boot_fetch_pkg::F_IDLE: begin
                    // launch the next line
                    cur_idx <= next_idx;
                    state   <= boot_fetch_pkg::F_BUS;
                end
                boot_fetch_pkg::F_BUS: begin
                    if (bus_ack_i) begin
                        state <= boot_fetch_pkg::F_PUSH;
                    end
                end
                boot_fetch_pkg::F_DROP: begin
                    // stale line arrives and is simply not kept
                    if (bus_ack_i) begin
                        state <= boot_fetch_pkg::F_IDLE;
                    end
                end
                default: begin
                    if (!q_full_i) begin
                        next_idx <= inc_idx;
                        state    <= boot_fetch_pkg::F_IDLE;
                    end
                end
            endcase

            // a redirect overrides whatever the case above chose
            if (redirect_i) begin
                next_idx <= redirect_pc_i[boot_fetch_pkg::ADDR_W-1 -: boot_fetch_pkg::LINE_IDX_W];
                if (in_flight && !bus_ack_i) begin
                    state <= boot_fetch_pkg::F_DROP;
                end else begin
                    state <= boot_fetch_pkg::F_IDLE;
                end
            end
        end
    end

    // the line holding register loads on the acknowledge edge
    always_ff @(posedge clk_i) begin
        if (state == boot_fetch_pkg::F_BUS && bus_ack_i) begin
            q_line_o <= bus_dat_i;
        end
    end

endmodule

// ==== insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              q_empty_i,
    input  logic [boot_fetch_pkg::LINE_W-1:0] q_head_line_i,
    input  logic [boot_fetch_pkg::ADDR_W-1:0] q_head_addr_i,
    output logic                              q_pop_o,
    input  logic                              stall_i,
    output logic                              redirect_o,
    output logic [boot_fetch_pkg::ADDR_W-1:0] redirect_pc_o,
    output logic                              insn_valid_o,
    output logic [boot_fetch_pkg::INSN_W-1:0] insn_o,
    output logic [boot_fetch_pkg::ADDR_W-1:0] insn_pc_o,
    output boot_fetch_pkg::insn_op_e          insn_op_o,
    output logic                              halted_o
);

    // pc of the next instruction the stream expects
    logic [boot_fetch_pkg::ADDR_W-1:0] pc_q;
    logic [1:0]                        slot;
    logic [boot_fetch_pkg::INSN_W-1:0] word;
    boot_fetch_pkg::insn_op_e          word_op;
    logic [boot_fetch_pkg::ADDR_W-1:0] jmp_target;
    logic                              head_hit;
    logic                              halt_wait;
    logic                              can_emit;
    logic                              is_jmp;

    // ========================================
    // pick and classify the current word
    // ========================================

    assign slot       = pc_q[3:2];
    assign word       = q_head_line_i[slot*boot_fetch_pkg::INSN_W +: boot_fetch_pkg::INSN_W];
    assign word_op    = boot_fetch_pkg::decode_op(word[31:29]);
    assign is_jmp     = (word_op == boot_fetch_pkg::OP_JMP);
    // jump targets are word aligned, the low two bits are ignored
    assign jmp_target = {word[boot_fetch_pkg::ADDR_W-1:2], 2'b00};

    // the head is only usable when it holds the line of the expected pc
    assign head_hit = !q_empty_i &&
        (q_head_addr_i[boot_fetch_pkg::ADDR_W-1 -: boot_fetch_pkg::LINE_IDX_W] ==
         pc_q[boot_fetch_pkg::ADDR_W-1 -: boot_fetch_pkg::LINE_IDX_W]);

    // a halt on the output blocks everything behind it until it is taken
    assign halt_wait = insn_valid_o && (insn_op_o == boot_fetch_pkg::OP_HALT);

    // nothing is issued in the flush cycle of a redirect, the head is stale then
    assign can_emit = head_hit && !halted_o && !halt_wait && !redirect_o &&
                      (!insn_valid_o || !stall_i);

    // release the head after its last slot or after a jump out of it,
    // and drop any head that does not belong to the expected pc
    assign q_pop_o = (can_emit && (slot == 2'd3 || is_jmp)) ||
                     (!q_empty_i && !head_hit && !redirect_o);

    // ========================================
    // control and output registers
    // ========================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q         <= boot_fetch_pkg::RESET_PC;
            insn_valid_o <= 1'b0;
            redirect_o   <= 1'b0;
            halted_o     <= 1'b0;
        end else begin
            redirect_o <= 1'b0;
            if (can_emit) begin
                insn_valid_o <= 1'b1;
                if (is_jmp) begin
                    // redirect rises together with the jump on the output
                    pc_q       <= jmp_target;
                    redirect_o <= 1'b1;
                end else begin
                    pc_q <= pc_q + boot_fetch_pkg::ADDR_W'(4);
                end
            end else if (!stall_i) begin
                insn_valid_o <= 1'b0;
                // halted rises on the edge that takes the halt
                if (halt_wait) begin
                    halted_o <= 1'b1;
                end
            end
        end
    end

    // payload only moves on issue, so a stall holds it as is
    always_ff @(posedge clk_i) begin
        if (can_emit) begin
            insn_o        <= word;
            insn_pc_o     <= pc_q;
            insn_op_o     <= word_op;
            redirect_pc_o <= jmp_target;
        end
    end

endmodule

// ==== line_queue.sv ====
`timescale 1ns/1ps

module line_queue (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              flush_i,
    input  logic                              push_i,
    input  logic [boot_fetch_pkg::LINE_W-1:0] line_i,
    input  logic [boot_fetch_pkg::ADDR_W-1:0] line_addr_i,
    input  logic                              pop_i,
    output logic                              full_o,
    output logic                              empty_o,
    output logic [boot_fetch_pkg::LINE_W-1:0] head_line_o,
    output logic [boot_fetch_pkg::ADDR_W-1:0] head_addr_o
);

    logic [boot_fetch_pkg::LINE_W-1:0] line_mem [boot_fetch_pkg::QUEUE_DEPTH];
    logic [boot_fetch_pkg::ADDR_W-1:0] addr_mem [boot_fetch_pkg::QUEUE_DEPTH];

    // pointers wrap on their own since the depth is a power of two
    logic [$clog2(boot_fetch_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(boot_fetch_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(boot_fetch_pkg::QUEUE_DEPTH):0]   count;
    logic                                           do_push;
    logic                                           do_pop;

    assign full_o  = (count == boot_fetch_pkg::QUEUE_DEPTH);
    assign empty_o = (count == 0);

    // flush wins over both push and pop in the same cycle
    assign do_push = push_i && !full_o && !flush_i;
    assign do_pop  = pop_i && !empty_o && !flush_i;

    // head entry is shown straight from storage
    assign head_line_o = line_mem[rd_ptr];
    assign head_addr_o = addr_mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry storage written at the write pointer on each push
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            line_mem[wr_ptr] <= line_i;
            addr_mem[wr_ptr] <= line_addr_i;
        end
    end

endmodule
